// ==== hdl/hf_pkg.sv ====
`default_nettype none

package hf_pkg;

    // Width of the raw ADC sample bus
    localparam int ADC_WIDTH = 8;

    // The fabric divider is wide enough for the slow on-off bit above the serial clock
    localparam int DIV_WIDTH = 7;

    localparam int FRAME_WIDTH = 3; // One frame every 8 serial clocks

    // Top level operating mode
    typedef enum logic [1:0] {
        mode_simulate = 2'd0,
        mode_read_tx  = 2'd1,
        mode_off      = 2'd2
    } major_mode_e;

    // Tag load modulation type
    // Codes 3 to 7 are not listed and behave as listen
    typedef enum logic [2:0] {
        mod_listen = 3'd0,
        mod_bpsk   = 3'd1,
        mod_ook    = 3'd2
    } mod_type_e;

endpackage

`default_nettype wire

// ==== hdl/ssp_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ssp_if
    import hf_pkg::*;
();

    logic [DIV_WIDTH-1:0] div_count; // Free running fabric divider
    logic                 sck;
    logic                 sck_rise;  // High in the cycle before sck goes high
    logic                 sck_fall;
    logic                 frame_tx_zero;
    logic                 frame_rx_zero; // Frame counter stepped on the falling enable

    modport source (
        output div_count,
        output sck,
        output sck_rise,
        output sck_fall,
        output frame_tx_zero,
        output frame_rx_zero
    );

    modport sink (
        input div_count,
        input sck,
        input sck_rise,
        input sck_fall,
        input frame_tx_zero,
        input frame_rx_zero
    );

endinterface

`default_nettype wire

// ==== hdl/ssp_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ssp_clock_gen
    import hf_pkg::*;
#(
    parameter int SCK_BIT = 4
) (
    input  wire    ssp_clk,
    input  wire    rst_n,
    ssp_if.source  ssp
);

    logic [DIV_WIDTH-1:0]   div_count;
    logic [FRAME_WIDTH-1:0] frame_tx_cnt;
    logic [FRAME_WIDTH-1:0] frame_rx_cnt;
    logic                   low_bits_full;

    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_count <= '0;
        end
        else
        begin
            div_count <= div_count + 1'b1;
        end
    end

    // Everything below the serial clock bit is about to wrap
    assign low_bits_full = &div_count[SCK_BIT-1:0];

    assign ssp.div_count = div_count;
    assign ssp.sck       = div_count[SCK_BIT];
    assign ssp.sck_rise  = low_bits_full & ~div_count[SCK_BIT];
    assign ssp.sck_fall  = low_bits_full & div_count[SCK_BIT];

    // The two frame phases differ by half a serial clock
    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_tx_cnt <= '0;
            frame_rx_cnt <= '0;
        end
        else
        begin
            if (ssp.sck_rise)
            begin
                frame_tx_cnt <= frame_tx_cnt + 1'b1;
            end
            if (ssp.sck_fall)
            begin
                frame_rx_cnt <= frame_rx_cnt + 1'b1;
            end
        end
    end

    assign ssp.frame_tx_zero = (frame_tx_cnt == '0);
    assign ssp.frame_rx_zero = (frame_rx_cnt == '0);

endmodule

`default_nettype wire

// ==== hdl/hi_simulate.sv ====
`timescale 1ns/1ps
`default_nettype none

module hi_simulate
    import hf_pkg::*;
#(
    parameter int SCK_BIT   = 4,
    parameter int HYST_BITS = 3
) (
    input  wire                  ssp_clk,
    input  wire                  rst_n,
    input  wire [ADC_WIDTH-1:0]  adc_d,
    input  wire                  ssp_dout,
    input  mod_type_e            mod_type,
    ssp_if.sink                  ssp,
    output logic                 ssp_din,
    output logic                 ssp_frame,
    output logic [3:0]           pwr_oe,
    output logic                 dbg
);

    logic [HYST_BITS-1:0] adc_top;
    logic                 after_hysteresis;
    logic                 use_rx_frame;
    logic                 mod_next;
    logic                 mod_q;

    assign adc_top = adc_d[ADC_WIDTH-1 -: HYST_BITS];

    // Strong field sets the state, no field clears it, anything between holds
    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            after_hysteresis <= 1'b0;
        end
        else if (&adc_top)
        begin
            after_hysteresis <= 1'b1;
        end
        else if (~|adc_top)
        begin
            after_hysteresis <= 1'b0;
        end
    end

    // A modulating tag reads its frame from the falling counter
    assign use_rx_frame = (mod_type == mod_bpsk) || (mod_type == mod_ook);

    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ssp_din   <= 1'b0;
            ssp_frame <= 1'b0;
        end
        else
        begin
            if (ssp.sck_rise)
            begin
                ssp_din <= after_hysteresis; // Changes together with sck rising
            end
            ssp_frame <= use_rx_frame ? ssp.frame_rx_zero : ssp.frame_tx_zero;
        end
    end

    always_comb
    begin
        case (mod_type)
            mod_bpsk: mod_next = ssp_dout ^ ssp.div_count[SCK_BIT-1]; // Subcarrier phase flip
            mod_ook:  mod_next = ssp_dout & ssp.div_count[SCK_BIT+1];
            default:  mod_next = 1'b0;
        endcase
    end

    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mod_q <= 1'b0;
        end
        else
        begin
            mod_q <= mod_next;
        end
    end

    // The third output enable never loads the antenna
    assign pwr_oe = {mod_q, 1'b0, mod_q, mod_q};
    assign dbg    = after_hysteresis;

endmodule

`default_nettype wire

// ==== hdl/hi_read_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module hi_read_tx
    import hf_pkg::*;
#(
    parameter int HYST_BITS = 3
) (
    input  wire                  ssp_clk,
    input  wire                  rst_n,
    input  wire [ADC_WIDTH-1:0]  adc_d,
    input  wire                  ssp_dout,
    ssp_if.sink                  ssp,
    output logic                 ssp_din,
    output logic                 ssp_frame,
    output logic                 pwr_hi,
    output logic                 dbg
);

    logic slice;
    logic slice_q;

    // Plain threshold on the top bits, with no memory of the previous level
    assign slice = &adc_d[ADC_WIDTH-1 -: HYST_BITS];

    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pwr_hi    <= 1'b0;
            ssp_din   <= 1'b0;
            ssp_frame <= 1'b0;
            slice_q   <= 1'b0;
        end
        else
        begin
            pwr_hi    <= ~ssp_dout; // The host keys the carrier off by driving a one
            ssp_frame <= ssp.frame_tx_zero;
            slice_q   <= slice;
            if (ssp.sck_rise)
            begin
                ssp_din <= slice;
            end
        end
    end

    assign dbg = slice_q;

endmodule

`default_nettype wire

// ==== hdl/fpga_hf.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpga_hf
    import hf_pkg::*;
#(
    parameter int SCK_BIT   = 4,
    parameter int HYST_BITS = 3
) (
    input  wire                  ssp_clk,
    input  wire                  rst_n,
    input  major_mode_e          major_mode,
    input  mod_type_e            mod_type,
    input  wire [ADC_WIDTH-1:0]  adc_d,
    input  wire                  ssp_dout,
    input  wire                  cross_hi,
    input  wire                  cross_lo,
    output logic                 adc_clk,
    output logic                 pwr_lo,
    output logic                 pwr_hi,
    output logic                 pwr_oe1,
    output logic                 pwr_oe2,
    output logic                 pwr_oe3,
    output logic                 pwr_oe4,
    output logic                 ssp_sck,
    output logic                 ssp_frame,
    output logic                 ssp_din,
    output logic                 dbg
);

    logic [3:0] sim_pwr_oe;
    logic       sim_ssp_din;
    logic       sim_ssp_frame;
    logic       sim_dbg;
    logic       tx_pwr_hi;
    logic       tx_ssp_din;
    logic       tx_ssp_frame;
    logic       tx_dbg;
    logic [3:0] pwr_oe_q;

    ssp_if ssp_bus ();

    ssp_clock_gen #(
        .SCK_BIT (SCK_BIT)
    ) ssp_clock_gen_inst (
        .ssp_clk (ssp_clk),
        .rst_n   (rst_n),
        .ssp     (ssp_bus.source)
    );

    hi_simulate #(
        .SCK_BIT   (SCK_BIT),
        .HYST_BITS (HYST_BITS)
    ) hi_simulate_inst (
        .ssp_clk   (ssp_clk),
        .rst_n     (rst_n),
        .adc_d     (adc_d),
        .ssp_dout  (ssp_dout),
        .mod_type  (mod_type),
        .ssp       (ssp_bus.sink),
        .ssp_din   (sim_ssp_din),
        .ssp_frame (sim_ssp_frame),
        .pwr_oe    (sim_pwr_oe),
        .dbg       (sim_dbg)
    );

    hi_read_tx #(
        .HYST_BITS (HYST_BITS)
    ) hi_read_tx_inst (
        .ssp_clk   (ssp_clk),
        .rst_n     (rst_n),
        .adc_d     (adc_d),
        .ssp_dout  (ssp_dout),
        .ssp       (ssp_bus.sink),
        .ssp_din   (tx_ssp_din),
        .ssp_frame (tx_ssp_frame),
        .pwr_hi    (tx_pwr_hi),
        .dbg       (tx_dbg)
    );

    // The pad register stage keeps the inactive mode off the pins
    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pwr_oe_q  <= '0;
            pwr_hi    <= 1'b0;
            ssp_din   <= 1'b0;
            ssp_frame <= 1'b0;
            dbg       <= 1'b0;
        end
        else
        begin
            case (major_mode)
                mode_simulate:
                begin
                    pwr_oe_q  <= sim_pwr_oe;
                    pwr_hi    <= 1'b0;
                    ssp_din   <= sim_ssp_din;
                    ssp_frame <= sim_ssp_frame;
                    dbg       <= sim_dbg;
                end
                mode_read_tx:
                begin
                    pwr_oe_q  <= '0; // The reader drives through pwr_hi only
                    pwr_hi    <= tx_pwr_hi;
                    ssp_din   <= tx_ssp_din;
                    ssp_frame <= tx_ssp_frame;
                    dbg       <= tx_dbg;
                end
                default:
                begin
                    pwr_oe_q  <= '0;
                    pwr_hi    <= 1'b0;
                    ssp_din   <= 1'b0;
                    ssp_frame <= 1'b0;
                    dbg       <= 1'b0;
                end
            endcase
        end
    end

    assign pwr_oe1 = pwr_oe_q[0];
    assign pwr_oe2 = pwr_oe_q[1];
    assign pwr_oe3 = pwr_oe_q[2];
    assign pwr_oe4 = pwr_oe_q[3];

    // Neither mode uses the low-power driver
    assign pwr_lo  = 1'b0;

    assign adc_clk = ssp_clk; // ADC samples on the fabric clock
    assign ssp_sck = ssp_bus.sck;

endmodule

`default_nettype wire

// ==== test/fpga_hf_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpga_hf_sva
    import hf_pkg::*;
(
    input wire         ssp_clk,
    input wire         rst_n,
    input major_mode_e major_mode,
    input mod_type_e   mod_type,
    input wire         pwr_lo,
    input wire         pwr_hi,
    input wire         pwr_oe1,
    input wire         pwr_oe2,
    input wire         pwr_oe3,
    input wire         pwr_oe4,
    input wire         ssp_sck,
    input wire         ssp_frame,
    input wire         ssp_din,
    input wire         dbg
);

    int unsigned fail_count = 0;
    major_mode_e major_mode_q;
    mod_type_e   mod_type_q;
    logic [2:0]  settle; // Cycles since the last mode or type change

    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            major_mode_q <= mode_off;
            mod_type_q   <= mod_listen;
            settle       <= '0;
        end
        else
        begin
            major_mode_q <= major_mode;
            mod_type_q   <= mod_type;
            if (major_mode != major_mode_q || mod_type != mod_type_q)
                settle <= '0;
            else if (settle != 3'd7)
                settle <= settle + 1'b1;
        end
    end

    reset_pads_low: assert property (@(posedge ssp_clk)
        !rst_n |-> !(pwr_hi || pwr_oe1 || pwr_oe2 || pwr_oe3 || pwr_oe4 ||
                     ssp_frame || ssp_din || dbg))
        else
        begin
            $error("pad output high while reset is held");
            fail_count++;
        end

    unused_drivers_low: assert property (@(posedge ssp_clk) !pwr_lo && !pwr_oe3)
        else
        begin
            $error("pwr_lo or pwr_oe3 driven high");
            fail_count++;
        end

    // Both frame counters step on a serial clock edge, and the pads lag by two cycles
    frame_follows_sck: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        settle == 3'd7 && $changed(ssp_frame) |-> $past(ssp_sck, 2) != $past(ssp_sck, 3))
        else
        begin
            $error("ssp_frame changed away from a serial clock edge");
            fail_count++;
        end

endmodule

bind fpga_hf fpga_hf_sva fpga_hf_checks (.*);

`default_nettype wire

// ==== test/tb_fpga_hf.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_hf
    import hf_pkg::*;
();

    localparam int SCK_BIT      = 4;
    localparam int HYST_BITS    = 3;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 3;
    localparam int OFF_CYCLES   = 40;
    localparam int SIM_CYCLES   = 320; // Longer than one frame of 256 cycles
    localparam int TX_CYCLES    = 200;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * OFF_CYCLES + 4 * SIM_CYCLES + TX_CYCLES + 4;
    localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD * 3 / 2;

    logic                 ssp_clk;
    logic                 rst_n;
    major_mode_e          major_mode;
    mod_type_e            mod_type;
    logic [ADC_WIDTH-1:0] adc_d;
    logic                 ssp_dout;
    logic                 cross_hi;
    logic                 cross_lo;
    logic                 adc_clk;
    logic                 pwr_lo;
    logic                 pwr_hi;
    logic                 pwr_oe1;
    logic                 pwr_oe2;
    logic                 pwr_oe3;
    logic                 pwr_oe4;
    logic                 ssp_sck;
    logic                 ssp_frame;
    logic                 ssp_din;
    logic                 dbg;

    // Reference model state
    logic [DIV_WIDTH-1:0]   div_m;
    logic [DIV_WIDTH-1:0]   div_next;
    logic [FRAME_WIDTH-1:0] tx_frame_m;
    logic [FRAME_WIDTH-1:0] rx_frame_m;
    logic [HYST_BITS-1:0]   adc_top;
    logic                   rise_m;
    logic                   fall_m;
    logic                   hyst_m;
    logic                   din_m;
    logic                   slice_m;
    logic                   tx_din_m;
    logic                   mod_exp;
    logic                   frame_exp;
    logic                   tx_zero_m;

    int          seed = 32'h0d447d9a;
    int          tb_errors = 0;
    int unsigned sva_errors;

    fpga_hf #(
        .SCK_BIT   (SCK_BIT),
        .HYST_BITS (HYST_BITS)
    ) fpga_hf_inst (.*);

    initial
    begin
        ssp_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ssp_clk = ~ssp_clk;
    end

    // An edge of the serial clock is due when divider bit SCK_BIT is about to flip
    assign div_next  = div_m + 1'b1;
    assign rise_m    = !div_m[SCK_BIT] && div_next[SCK_BIT];
    assign fall_m    = div_m[SCK_BIT] && !div_next[SCK_BIT];
    assign adc_top   = adc_d[ADC_WIDTH-1:ADC_WIDTH-HYST_BITS];
    assign slice_m   = (adc_top == '1); // Read transmit slices without hysteresis
    assign tx_zero_m = (tx_frame_m == '0);
    assign frame_exp = (mod_type == mod_bpsk || mod_type == mod_ook) ? (rx_frame_m == '0)
                                                                      : tx_zero_m;
    assign mod_exp   = (mod_type == mod_bpsk) ? (ssp_dout ^ div_m[SCK_BIT-1]) :
                       (mod_type == mod_ook)  ? (ssp_dout & div_m[SCK_BIT+1]) : 1'b0;

    always_ff @(posedge ssp_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_m      <= '0;
            tx_frame_m <= '0;
            rx_frame_m <= '0;
            hyst_m     <= 1'b0;
            din_m      <= 1'b0;
            tx_din_m   <= 1'b0;
        end
        else
        begin
            div_m <= div_next;
            if (rise_m)
                tx_frame_m <= tx_frame_m + 1'b1;
            if (fall_m)
                rx_frame_m <= rx_frame_m + 1'b1;
            if (adc_top == '1)
                hyst_m <= 1'b1;
            else if (adc_top == '0)
                hyst_m <= 1'b0; // Mixed top bits keep the last state
            if (rise_m)
                din_m <= hyst_m;
            if (rise_m)
                tx_din_m <= slice_m;
        end
    end

    task automatic report_error(input string msg);
        tb_errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic run_phase(input major_mode_e mode, input mod_type_e mtype, input int cycles);
        logic [31:0] rnd;
        major_mode = mode;
        mod_type   = mtype;
        repeat (cycles)
        begin
            rnd      = $random(seed);
            adc_d    = rnd[ADC_WIDTH-1:0];
            ssp_dout = rnd[ADC_WIDTH];
            @(posedge ssp_clk);
            #1;
        end
    endtask

    // The ADC clock is the fabric clock forwarded to the pad
    always @(ssp_clk)
    begin
        #1;
        adc_clk_forwarded: assert (adc_clk === ssp_clk)
            else report_error("adc_clk does not follow ssp_clk");
    end

    sck_from_divider: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        ssp_sck == div_m[SCK_BIT])
        else report_error("ssp_sck differs from the divider model");

    off_outputs_low: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        $past(major_mode) == mode_off |->
            !(pwr_hi || pwr_lo || pwr_oe1 || pwr_oe2 || pwr_oe3 || pwr_oe4 ||
              ssp_frame || ssp_din || dbg))
        else report_error("pad output high in mode_off");

    sim_dbg_hysteresis: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        $past(major_mode) == mode_simulate |-> dbg == $past(hyst_m))
        else report_error("dbg differs from the hysteresis model");

    sim_din_on_rise: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        $past(major_mode) == mode_simulate |-> ssp_din == $past(din_m))
        else report_error("ssp_din differs from the sliced bit at sck rise");

    sim_frame_phase: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        $past(major_mode) == mode_simulate |-> ssp_frame == $past(frame_exp, 2))
        else report_error("ssp_frame has the wrong phase for the modulation type");

    sim_load_modulation: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        $past(major_mode) == mode_simulate |->
            pwr_oe1 == $past(mod_exp, 2) && pwr_oe2 == $past(mod_exp, 2) &&
            pwr_oe4 == $past(mod_exp, 2) && !pwr_oe3 && !pwr_hi)
        else report_error("pwr_oe pattern differs from the modulation rule");

    tx_carrier_keying: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        $past(major_mode) == mode_read_tx |->
            pwr_hi == !$past(ssp_dout, 2) && !(pwr_oe1 || pwr_oe2 || pwr_oe3 || pwr_oe4))
        else report_error("pwr_hi is not the inverted host bit");

    tx_frame_phase: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        $past(major_mode) == mode_read_tx |-> ssp_frame == $past(tx_zero_m, 2))
        else report_error("ssp_frame in read transmit does not follow the rising counter");

    tx_slice_to_host: assert property (@(posedge ssp_clk) disable iff (!rst_n)
        $past(major_mode) == mode_read_tx |->
            ssp_din == $past(tx_din_m) && dbg == $past(slice_m, 2))
        else report_error("ssp_din or dbg in read transmit differs from the threshold slice");

    initial
    begin
        rst_n      = 1'b1;
        major_mode = mode_off;
        mod_type   = mod_listen;
        adc_d      = '0;
        ssp_dout   = 1'b0;
        cross_hi   = 1'b0;
        cross_lo   = 1'b0;
        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge ssp_clk);
        #1;
        rst_n = 1'b1;
        run_phase(mode_off, mod_listen, OFF_CYCLES);
        run_phase(mode_simulate, mod_listen, SIM_CYCLES);
        run_phase(mode_simulate, mod_bpsk, SIM_CYCLES);
        run_phase(mode_simulate, mod_ook, SIM_CYCLES);
        run_phase(mode_simulate, mod_type_e'(3'd5), SIM_CYCLES); // Undefined code
        run_phase(mode_read_tx, mod_listen, TX_CYCLES);
        run_phase(mode_off, mod_listen, OFF_CYCLES);
        repeat (3) @(posedge ssp_clk);
        sva_errors = fpga_hf_inst.fpga_hf_checks.fail_count;
        $display("Checks done: %0d testbench errors, %0d bound assertion errors",
                 tb_errors, sva_errors);
        if (tb_errors == 0 && sva_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/hf_pkg.sv
hdl/ssp_if.sv
hdl/ssp_clock_gen.sv
hdl/hi_simulate.sv
hdl/hi_read_tx.sv
hdl/fpga_hf.sv
test/fpga_hf_sva.sv
test/tb_fpga_hf.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_fpga_hf -f project.f -Mdir obj_dir -o sim_fpga_hf; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/sim_fpga_hf +verilator+error+limit+1000); then
    printf '%s\n' "$output"
    echo "Simulation exited with an error status"
    exit 1
fi

printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi

echo "Pass line not found in the simulation output"
exit 1
